// ==== bench/link_txrx_tb.sv ====
// Loopback testbench for the link engine, one clock domain
// TX lane feeds RX through an injector that can flip bits or force idle
// The model decodes the TX lane and predicts every RX strobe and status update

`timescale 1ns/10ps

module link_txrx_tb;

   import link_pkg::*;

   typedef struct packed {
      payload_t   data;
      location_t  loc;
      frame_cnt_t cnt;
   } frame_exp_t;

   logic        gtx_tx_clk;
   logic        rst_n;
   logic        tx_transmit_en;
   logic        tx_valid;
   location_t   tx_location;
   payload_t    tx_data;
   logic        tx_send;
   lane_word_t  gtx_tx_d;
   lane_k_t     gtx_tx_k;
   lane_word_t  gtx_rx_d;
   lane_k_t     gtx_rx_k;
   logic        rx_valid;
   payload_t    rx_data;
   logic        ccrx_frame_drop;
   fault_t      ccrx_fault;
   logic        ccrx_los;
   logic [3:0]  rx_protocol_ver;
   logic [2:0]  rx_gateware_type;
   location_t   rx_location;
   logic [31:0] rx_rev_id;
   frame_cnt_t  rx_frame_counter;
   frame_cnt_t  ccrx_fault_cnt;
   frame_cnt_t  txrx_latency;

   // Loopback injector controls
   logic        force_idle;
   lane_word_t  err_mask;

   // Model state
   integer      seed = 61;
   frame_exp_t  exp_q[$];
   frame_exp_t  cur;
   frame_exp_t  shown;
   payload_t    pend_data;
   location_t   pend_loc;
   lane_word_t  words [1:10];
   lane_word_t  crc_m;
   logic [3:0]  tx_idx;
   logic        frame_err;
   logic        frame_forced;
   logic        exp_valid;
   logic        exp_drop;
   logic        id_due;
   logic        cnt_due;
   logic        en_prev;
   frame_cnt_t  last_cnt;
   frame_cnt_t  last_echo;
   frame_cnt_t  exp_lat;
   frame_cnt_t  fault_cnt_m;
   int          good_cnt;
   int          drop_cnt;

   always #5 gtx_tx_clk = ~gtx_tx_clk;

   link_txrx i_link_txrx (.*);

   assign gtx_rx_d = force_idle ? K_IDLE : (gtx_tx_d ^ err_mask);
   assign gtx_rx_k = force_idle ? K_COMMA : gtx_tx_k;

   // CRC-16, poly 0x1021, one bit per step from the word's MSB
   function automatic logic [15:0] crc_next(input logic [15:0] crc, input logic [15:0] w);
      logic [15:0] r;
      logic        fb;
      int          b;
      r = crc;
      for (b = 15; b >= 0; b--) begin
         fb = r[15] ^ w[b];
         r  = {r[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
         $display("Verification failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      $display("Verification failed");
      $fatal(1, "wait timed out");
   endtask

   // --------------------------------------------------
   // Lane model and receive checks
   // --------------------------------------------------
   always @(negedge gtx_tx_clk) begin
      if (rst_n) begin
         check_value("rx_valid", rx_valid, exp_valid);
         check_value("ccrx_frame_drop", ccrx_frame_drop, exp_drop);
         if (id_due) begin
            check_value("rx_location", rx_location, shown.loc);
            check_value("rx_protocol_ver", rx_protocol_ver, PROTOCOL_VER);
            check_value("rx_gateware_type", rx_gateware_type, GATEWARE_TYPE);
            check_value("rx_rev_id", rx_rev_id, REV_ID);
            check_value("rx_frame_counter", rx_frame_counter, shown.cnt);
            check_value("txrx_latency", txrx_latency, exp_lat);
            check_value("ccrx_fault_cnt", ccrx_fault_cnt, fault_cnt_m);
            id_due = 1'b0;
         end
         if (cnt_due) begin
            fault_cnt_m = fault_cnt_m + 16'd1;
            check_value("ccrx_fault_cnt", ccrx_fault_cnt, fault_cnt_m);
            cnt_due = 1'b0;
         end
         if (exp_valid) begin
            shown = exp_q.pop_front();
            check_value("rx_data", rx_data, shown.data);
            check_value("ccrx_fault", ccrx_fault, 3'b000);
            check_value("ccrx_los", ccrx_los, 1'b0);
            // Newest frame on the lane minus its own echo field
            exp_lat  = last_cnt - last_echo;
            id_due   = 1'b1;
            good_cnt = good_cnt + 1;
         end
         if (exp_drop) begin
            check_value("ccrx_fault", ccrx_fault, 3'b001);
            cnt_due  = 1'b1;
            drop_cnt = drop_cnt + 1;
         end
         exp_valid = 1'b0;
         exp_drop  = 1'b0;

         if (gtx_tx_k == K_COMMA && gtx_tx_d == K_SOF) begin
            check_value("tx_send", tx_send, 1'b1);
            check_value("gap before K_SOF", tx_idx >= 4'd11, 1'b1);
            // Enable as seen on the edge that started this frame
            check_value("tx_transmit_en at K_SOF", en_prev, 1'b1);
            tx_idx       = 4'd0;
            crc_m        = 16'hFFFF;
            frame_err    = 1'b0;
            frame_forced = force_idle;
            cur.data     = pend_data;
            cur.loc      = pend_loc;
         end else if (tx_idx < 4'd10) begin
            check_value("tx_send", tx_send, 1'b0);
            check_value("gtx_tx_k", gtx_tx_k, 2'b00);
            tx_idx        = tx_idx + 4'd1;
            words[tx_idx] = gtx_tx_d;
            frame_err     = frame_err | (err_mask != 16'h0000);
            if (tx_idx < 4'd10) begin
               crc_m = crc_next(crc_m, gtx_tx_d);
            end else begin
               check_value("crc word", gtx_tx_d, crc_m);
               check_value("header word", words[1],
                           {PROTOCOL_VER, GATEWARE_TYPE, cur.loc, 6'd0});
               check_value("rev_id words", {words[2], words[3]}, REV_ID);
               check_value("payload words", {words[4], words[5], words[6], words[7]},
                           cur.data);
               check_value("frame counter word", words[8], last_cnt + 16'd1);
               cur.cnt   = words[8];
               last_cnt  = words[8];
               last_echo = words[9];
               // A fully forced frame never reaches the receiver
               if (!frame_forced && frame_err) begin
                  exp_drop = 1'b1;
               end else if (!frame_forced) begin
                  exp_q.push_back(cur);
                  exp_valid = 1'b1;
               end
            end
         end else begin
            check_value("tx_send", tx_send, 1'b0);
            check_value("gtx_tx_d idle", gtx_tx_d, 16'h50BC);
            check_value("gtx_tx_k idle", gtx_tx_k, 2'b01);
            // Past the gap word an enabled TX must have started a frame
            if (tx_idx != 4'd10)
               check_value("tx_transmit_en without K_SOF", en_prev, 1'b0);
            tx_idx = (tx_idx == 4'd10) ? 4'd11 : 4'd15;
         end

         // Strobe seen now belongs to the next frame start
         if (tx_valid) begin
            pend_data = tx_data;
            pend_loc  = tx_location;
         end
         en_prev = tx_transmit_en;
      end
   end

   // --------------------------------------------------
   // Stimulus tasks
   // --------------------------------------------------
   task automatic await_good_frames(input int n);
      int target;
      int t;
      target = good_cnt + n;
      for (t = 0; t < 12 * n + 40 && good_cnt < target; t++)
         @(posedge gtx_tx_clk);
      if (good_cnt < target)
         report_timeout("a good frame on rx_valid never arrived");
   endtask

   // Returns on the edge that follows a gap word
   task automatic sync_to_gap();
      int t;
      t = 0;
      do begin
         @(posedge gtx_tx_clk);
         t++;
      end while (tx_idx != 4'd11 && t < 30);
      if (tx_idx != 4'd11)
         report_timeout("no gap word after a frame on gtx_tx_d");
   endtask

   task automatic send_payload();
      int r;
      r = $random(seed);
      repeat ({r} % 12 + 1) @(posedge gtx_tx_clk);
      r = $random(seed);
      tx_valid    <= 1'b1;
      tx_data     <= {$random(seed), $random(seed)};
      tx_location <= r[2:0];
      @(posedge gtx_tx_clk);
      // Sometimes a second strobe follows, the last one wins
      if (r[7:6] == 2'b00) begin
         tx_data <= {$random(seed), $random(seed)};
         @(posedge gtx_tx_clk);
      end
      tx_valid <= 1'b0;
   endtask

   task automatic inject_error();
      int         w;
      int         t;
      int         drops;
      int         r;
      lane_word_t mask;
      r     = $random(seed);
      w     = 2 + {r} % 9;
      r     = $random(seed);
      mask  = (r[15:0] == 16'h0000) ? 16'h0001 : r[15:0];
      drops = drop_cnt;
      t     = 0;
      do begin
         @(posedge gtx_tx_clk);
         t++;
      end while (tx_idx != w - 1 && t < 30);
      if (tx_idx != w - 1)
         report_timeout("frame word before the target word never came");
      err_mask <= mask;
      @(posedge gtx_tx_clk);
      err_mask <= 16'h0000;
      for (t = 0; t < 30 && drop_cnt == drops; t++)
         @(posedge gtx_tx_clk);
      if (drop_cnt == drops)
         report_timeout("ccrx_frame_drop never pulsed for a corrupted frame");
      await_good_frames(1);
   endtask

   // Forces n + 1 whole frames to idle
   task automatic force_idle_frames(input int n);
      sync_to_gap();
      force_idle <= 1'b1;
      repeat (n) sync_to_gap();
      @(negedge gtx_tx_clk);
      check_value("ccrx_los", ccrx_los, 1'b1);
      sync_to_gap();
      force_idle <= 1'b0;
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      int i;
      gtx_tx_clk     = 1'b0;
      rst_n          = 1'b0;
      tx_transmit_en = 1'b0;
      tx_valid       = 1'b0;
      tx_location    = '0;
      tx_data        = '0;
      force_idle     = 1'b0;
      err_mask       = 16'h0000;
      pend_data      = '0;
      pend_loc       = '0;
      tx_idx         = 4'd15;
      exp_valid      = 1'b0;
      exp_drop       = 1'b0;
      id_due         = 1'b0;
      cnt_due        = 1'b0;
      en_prev        = 1'b0;
      last_cnt       = '0;
      last_echo      = '0;
      fault_cnt_m    = '0;
      good_cnt       = 0;
      drop_cnt       = 0;

      repeat (3) @(posedge gtx_tx_clk);
      rst_n <= 1'b1;
      @(negedge gtx_tx_clk);
      check_value("ccrx_los", ccrx_los, 1'b1);
      check_value("ccrx_fault", ccrx_fault, 3'b000);
      check_value("ccrx_fault_cnt", ccrx_fault_cnt, 16'd0);
      check_value("txrx_latency", txrx_latency, 16'd0);
      @(posedge gtx_tx_clk);
      tx_transmit_en <= 1'b1;

      for (i = 0; i < 16; i++) begin
         send_payload();
         await_good_frames(2);
      end
      for (i = 0; i < 8; i++)
         inject_error();

      // 84 forced cycles, well past LOS_WORDS
      force_idle_frames(6);
      await_good_frames(2);

      @(posedge gtx_tx_clk);
      tx_transmit_en <= 1'b0;
      repeat (48) @(posedge gtx_tx_clk);
      tx_transmit_en <= 1'b1;
      await_good_frames(3);

      send_payload();
      inject_error();
      await_good_frames(2);

      $display("Verification passed");
      $finish;
   end

endmodule

// ==== filelist.f ====
hw/link_pkg.sv
hw/link_frame_tx.sv
hw/link_frame_rx.sv
hw/link_status.sv
hw/link_txrx.sv
bench/link_txrx_tb.sv

// ==== hw/link_frame_rx.sv ====
// Frame receiver on decoded lane words
// Non-comma K words inside a frame are collected as data and fail the CRC
// Loss of signal is raised after LOS_WORDS cycles without a good frame

`timescale 1ns/10ps

module link_frame_rx (
   input  logic                 gtx_tx_clk,
   input  logic                 rst_n,
   input  link_pkg::lane_word_t gtx_rx_d,
   input  link_pkg::lane_k_t    gtx_rx_k,
   output link_pkg::rx_frame_t  rx_frame,
   output logic                 rx_valid,
   output logic                 ccrx_frame_drop,
   output link_pkg::fault_t     ccrx_fault,
   output logic                 ccrx_los
);

   import link_pkg::*;

   typedef enum logic {
      ST_HUNT,
      ST_COLLECT
   } state_t;

   state_t     state;
   word_idx_t  word_cnt;
   lane_word_t crc;
   los_cnt_t   silence_cnt;

   // Words 1 to 9, oldest at the low index
   lane_word_t [WI_HDR:WI_ECHO] words;

   header_t rx_hdr;
   logic    is_sof;
   logic    at_crc;
   logic    crc_bad;
   logic    ver_bad;
   fault_t  fault_now;
   logic    frame_good;
   logic    frame_bad;

   // --------------------------------------------------
   // Frame checks
   // --------------------------------------------------
   always_comb begin
      rx_hdr  = words[WI_HDR];
      is_sof  = (gtx_rx_k == K_COMMA) && (gtx_rx_d == K_SOF);
      at_crc  = (state == ST_COLLECT) && (word_cnt == WI_CRC) && !is_sof;
      crc_bad = (crc != gtx_rx_d);
      ver_bad = (rx_hdr.protocol_ver != PROTOCOL_VER);

      fault_now = '0;
      if (state == ST_COLLECT && is_sof) begin
         fault_now[FAULT_BROKEN] = 1'b1;
      end else if (at_crc) begin
         fault_now[FAULT_CRC] = crc_bad;
         fault_now[FAULT_VER] = ver_bad;
      end
      frame_bad  = |fault_now;
      frame_good = at_crc && !crc_bad && !ver_bad;
   end

   // FSM, strobes, fault flags and LOS
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         state           <= ST_HUNT;
         word_cnt        <= '0;
         rx_valid        <= 1'b0;
         ccrx_frame_drop <= 1'b0;
         ccrx_fault      <= '0;
         silence_cnt     <= LOS_WORDS;
         ccrx_los        <= 1'b1;
      end else begin
         rx_valid        <= frame_good;
         ccrx_frame_drop <= frame_bad;

         if (frame_bad)
            ccrx_fault <= fault_now;
         else if (frame_good)
            ccrx_fault <= '0;

         if (frame_good) begin
            silence_cnt <= '0;
            ccrx_los    <= 1'b0;
         end else if (silence_cnt != LOS_WORDS) begin
            silence_cnt <= silence_cnt + 1'b1;
         end else begin
            ccrx_los <= 1'b1;
         end

         case (state)
            ST_HUNT: begin
               if (is_sof) begin
                  state    <= ST_COLLECT;
                  word_cnt <= WI_HDR;
               end
            end
            ST_COLLECT: begin
               // Restart on any start word
               if (is_sof)
                  word_cnt <= WI_HDR;
               else if (word_cnt == WI_CRC)
                  state <= ST_HUNT;
               else
                  word_cnt <= word_cnt + 4'd1;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // Word capture, CRC and frame decode
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (is_sof) begin
         crc <= CRC_SEED;
      end else if (state == ST_COLLECT && word_cnt != WI_CRC) begin
         crc   <= crc16_step(crc, gtx_rx_d);
         words <= {words[WI_REV_HI:WI_ECHO], gtx_rx_d};
      end

      // Held between good frames
      if (frame_good) begin
         rx_frame.payload.data1     <= {words[WI_D1_HI], words[WI_D1_LO]};
         rx_frame.payload.data0     <= {words[WI_D0_HI], words[WI_D0_LO]};
         rx_frame.protocol_ver      <= rx_hdr.protocol_ver;
         rx_frame.gateware_type     <= rx_hdr.gateware_type;
         rx_frame.location          <= rx_hdr.location;
         rx_frame.rev_id            <= {words[WI_REV_HI], words[WI_REV_LO]};
         rx_frame.frame_counter     <= words[WI_CNT];
         rx_frame.loopback_counter  <= words[WI_ECHO];
      end
   end

endmodule

// ==== hw/link_frame_tx.sv ====
// Frame transmitter, one frame every 12 cycles while enabled
// Payload strobes faster than the frame rate overwrite each other
// Enable is looked at only between frames

`timescale 1ns/10ps

module link_frame_tx (
   input  logic                 gtx_tx_clk,
   input  logic                 rst_n,
   input  logic                 tx_transmit_en,
   input  logic                 tx_valid,
   input  link_pkg::location_t  tx_location,
   input  link_pkg::payload_t   tx_data,
   input  link_pkg::frame_cnt_t loopback_counter,
   output link_pkg::frame_cnt_t local_counter,
   output logic                 tx_send,
   output link_pkg::lane_word_t gtx_tx_d,
   output link_pkg::lane_k_t    gtx_tx_k
);

   import link_pkg::*;

   logic       busy;
   word_idx_t  word_idx;
   word_idx_t  next_idx;
   logic       start;
   lane_word_t next_word;
   lane_k_t    next_k;
   header_t    hdr;

   payload_t   pend_data;
   location_t  pend_location;
   payload_t   frm_data;
   location_t  frm_location;
   frame_cnt_t frm_echo;
   lane_word_t crc;

   // New frame right after the gap word, or from idle
   assign start = tx_transmit_en && (!busy || word_idx == FRAME_PERIOD - 4'd1);

   // --------------------------------------------------
   // Word multiplexer
   // --------------------------------------------------
   always_comb begin
      next_idx = word_idx + 4'd1;
      hdr.protocol_ver  = PROTOCOL_VER;
      hdr.gateware_type = GATEWARE_TYPE;
      hdr.location      = frm_location;
      hdr.rsvd          = '0;
      next_word = K_IDLE;
      next_k    = K_COMMA;
      case (next_idx)
         WI_HDR:    next_word = hdr;
         WI_REV_HI: next_word = REV_ID[31:16];
         WI_REV_LO: next_word = REV_ID[15:0];
         WI_D1_HI:  next_word = frm_data.data1[31:16];
         WI_D1_LO:  next_word = frm_data.data1[15:0];
         WI_D0_HI:  next_word = frm_data.data0[31:16];
         WI_D0_LO:  next_word = frm_data.data0[15:0];
         WI_CNT:    next_word = local_counter;
         WI_ECHO:   next_word = frm_echo;
         WI_CRC:    next_word = crc;
         default:   next_word = K_IDLE;
      endcase
      if (next_idx >= WI_HDR && next_idx <= WI_CRC)
         next_k = K_DATA;
   end

   // Sequencing and lane output
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         busy          <= 1'b0;
         word_idx      <= '0;
         local_counter <= '0;
         tx_send       <= 1'b0;
         gtx_tx_d      <= K_IDLE;
         gtx_tx_k      <= K_COMMA;
         pend_data     <= '0;
         pend_location <= '0;
      end else begin
         tx_send <= start;
         if (tx_valid) begin
            pend_data     <= tx_data;
            pend_location <= tx_location;
         end
         if (start) begin
            busy          <= 1'b1;
            word_idx      <= '0;
            local_counter <= local_counter + 1'b1;
            gtx_tx_d      <= K_SOF;
            gtx_tx_k      <= K_COMMA;
         end else if (busy && word_idx == FRAME_PERIOD - 4'd1) begin
            busy     <= 1'b0;
            gtx_tx_d <= K_IDLE;
            gtx_tx_k <= K_COMMA;
         end else if (busy) begin
            word_idx <= next_idx;
            gtx_tx_d <= next_word;
            gtx_tx_k <= next_k;
         end
      end
   end

   // --------------------------------------------------
   // Frame snapshot and running CRC
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (start) begin
         // A strobe on the start cycle still makes this frame
         frm_data     <= tx_valid ? tx_data : pend_data;
         frm_location <= tx_valid ? tx_location : pend_location;
         frm_echo     <= loopback_counter;
         crc          <= CRC_SEED;
      end else if (busy && next_idx >= WI_HDR && next_idx <= WI_ECHO) begin
         crc <= crc16_step(crc, next_word);
      end
   end

endmodule

// ==== hw/link_pkg.sv ====
// Shared types and constants for the point-to-point link engine
// Lane words are taken as already 8b/10b decoded, one 16-bit word per clock
// Revision ID, gateware type and protocol version are fixed here

package link_pkg;

   typedef logic [15:0] lane_word_t;
   typedef logic [1:0]  lane_k_t;
   typedef logic [15:0] frame_cnt_t;
   typedef logic [2:0]  location_t;
   typedef logic [2:0]  fault_t;
   typedef logic [3:0]  word_idx_t;
   typedef logic [6:0]  los_cnt_t;

   typedef struct packed {
      logic [31:0] data1;
      logic [31:0] data0;
   } payload_t;

   // Layout of frame word 1
   typedef struct packed {
      logic [3:0] protocol_ver;
      logic [2:0] gateware_type;
      location_t  location;
      logic [5:0] rsvd;
   } header_t;

   typedef struct packed {
      payload_t    payload;
      logic [3:0]  protocol_ver;
      logic [2:0]  gateware_type;
      location_t   location;
      logic [31:0] rev_id;
      frame_cnt_t  frame_counter;
      frame_cnt_t  loopback_counter;
   } rx_frame_t;

   localparam logic [3:0]  PROTOCOL_VER  = 4'd1;
   localparam logic [2:0]  GATEWARE_TYPE = 3'd3;
   localparam logic [31:0] REV_ID        = 32'h0001_0A3B;

   // K-characters, comma in the low byte
   localparam lane_word_t K_SOF   = 16'h3CBC;
   localparam lane_word_t K_IDLE  = 16'h50BC;
   localparam lane_k_t    K_COMMA = 2'b01;
   localparam lane_k_t    K_DATA  = 2'b00;

   // --------------------------------------------------
   // Frame word positions
   // --------------------------------------------------
   localparam word_idx_t WI_HDR    = 4'd1;
   localparam word_idx_t WI_REV_HI = 4'd2;
   localparam word_idx_t WI_REV_LO = 4'd3;
   localparam word_idx_t WI_D1_HI  = 4'd4;
   localparam word_idx_t WI_D1_LO  = 4'd5;
   localparam word_idx_t WI_D0_HI  = 4'd6;
   localparam word_idx_t WI_D0_LO  = 4'd7;
   localparam word_idx_t WI_CNT    = 4'd8;
   localparam word_idx_t WI_ECHO   = 4'd9;
   localparam word_idx_t WI_CRC    = 4'd10;

   localparam word_idx_t FRAME_WORDS  = 4'd11;
   localparam word_idx_t FRAME_GAP    = 4'd1;
   localparam word_idx_t FRAME_PERIOD = FRAME_WORDS + FRAME_GAP;

   localparam los_cnt_t LOS_WORDS = 7'd64;

   localparam int FAULT_CRC    = 0;
   localparam int FAULT_BROKEN = 1;
   localparam int FAULT_VER    = 2;

   localparam lane_word_t CRC_SEED = 16'hFFFF;
   localparam lane_word_t CRC_POLY = 16'h1021;

   // One CRC-16 update over a full word, MSB first
   function automatic lane_word_t crc16_step(input lane_word_t crc, input lane_word_t word);
      lane_word_t c;
      int         i;
      c = crc;
      for (i = 15; i >= 0; i--) begin
         if (c[15] ^ word[i])
            c = {c[14:0], 1'b0} ^ CRC_POLY;
         else
            c = {c[14:0], 1'b0};
      end
      return c;
   endfunction

endpackage

// ==== hw/link_status.sv ====
// Status stage behind the receiver
// rx_data follows the held frame and is valid together with rx_valid
// Identity fields, fault count and latency update one cycle after rx_valid

`timescale 1ns/10ps

module link_status (
   input  logic                 gtx_tx_clk,
   input  logic                 rst_n,
   input  link_pkg::rx_frame_t  rx_frame,
   input  logic                 rx_valid,
   input  logic                 ccrx_frame_drop,
   input  link_pkg::frame_cnt_t local_counter,
   output link_pkg::payload_t   rx_data,
   output logic [3:0]           rx_protocol_ver,
   output logic [2:0]           rx_gateware_type,
   output link_pkg::location_t  rx_location,
   output logic [31:0]          rx_rev_id,
   output link_pkg::frame_cnt_t rx_frame_counter,
   output link_pkg::frame_cnt_t ccrx_fault_cnt,
   output link_pkg::frame_cnt_t txrx_latency,
   output link_pkg::frame_cnt_t last_rx_counter
);

   assign rx_data         = rx_frame.payload;
   assign last_rx_counter = rx_frame_counter;

   // --------------------------------------------------
   // Counters and round-trip latency
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         rx_frame_counter <= '0;
         ccrx_fault_cnt   <= '0;
         txrx_latency     <= '0;
      end else begin
         if (rx_valid) begin
            rx_frame_counter <= rx_frame.frame_counter;
            // Frames in flight between our send and its echo coming back
            txrx_latency     <= local_counter - rx_frame.loopback_counter;
         end
         // Saturates at all ones
         if (ccrx_frame_drop && ccrx_fault_cnt != '1)
            ccrx_fault_cnt <= ccrx_fault_cnt + 1'b1;
      end
   end

   // Identity of the far end
   always_ff @(posedge gtx_tx_clk) begin
      if (rx_valid) begin
         rx_protocol_ver  <= rx_frame.protocol_ver;
         rx_gateware_type <= rx_frame.gateware_type;
         rx_location      <= rx_frame.location;
         rx_rev_id        <= rx_frame.rev_id;
      end
   end

endmodule

// ==== hw/link_txrx.sv ====
// Link engine top, single clock domain
// The far end's echo counter closes the latency loop through the status stage

`timescale 1ns/10ps

module link_txrx (
   input  logic                 gtx_tx_clk,
   input  logic                 rst_n,
   input  logic                 tx_transmit_en,
   input  logic                 tx_valid,
   input  link_pkg::location_t  tx_location,
   input  link_pkg::payload_t   tx_data,
   output logic                 tx_send,
   output link_pkg::lane_word_t gtx_tx_d,
   output link_pkg::lane_k_t    gtx_tx_k,
   input  link_pkg::lane_word_t gtx_rx_d,
   input  link_pkg::lane_k_t    gtx_rx_k,
   output logic                 rx_valid,
   output link_pkg::payload_t   rx_data,
   output logic                 ccrx_frame_drop,
   output link_pkg::fault_t     ccrx_fault,
   output logic                 ccrx_los,
   output logic [3:0]           rx_protocol_ver,
   output logic [2:0]           rx_gateware_type,
   output link_pkg::location_t  rx_location,
   output logic [31:0]          rx_rev_id,
   output link_pkg::frame_cnt_t rx_frame_counter,
   output link_pkg::frame_cnt_t ccrx_fault_cnt,
   output link_pkg::frame_cnt_t txrx_latency
);

   import link_pkg::*;

   frame_cnt_t local_counter;
   frame_cnt_t last_rx_counter;
   rx_frame_t  rx_frame;

   // --------------------------------------------------
   // TX stage
   // --------------------------------------------------
   link_frame_tx i_link_frame_tx (
      .gtx_tx_clk       (gtx_tx_clk),
      .rst_n            (rst_n),
      .tx_transmit_en   (tx_transmit_en),
      .tx_valid         (tx_valid),
      .tx_location      (tx_location),
      .tx_data          (tx_data),
      .loopback_counter (last_rx_counter),
      .local_counter    (local_counter),
      .tx_send          (tx_send),
      .gtx_tx_d         (gtx_tx_d),
      .gtx_tx_k         (gtx_tx_k)
   );

   // --------------------------------------------------
   // RX stages
   // --------------------------------------------------
   link_frame_rx i_link_frame_rx (
      .gtx_tx_clk      (gtx_tx_clk),
      .rst_n           (rst_n),
      .gtx_rx_d        (gtx_rx_d),
      .gtx_rx_k        (gtx_rx_k),
      .rx_frame        (rx_frame),
      .rx_valid        (rx_valid),
      .ccrx_frame_drop (ccrx_frame_drop),
      .ccrx_fault      (ccrx_fault),
      .ccrx_los        (ccrx_los)
   );

   link_status i_link_status (
      .gtx_tx_clk       (gtx_tx_clk),
      .rst_n            (rst_n),
      .rx_frame         (rx_frame),
      .rx_valid         (rx_valid),
      .ccrx_frame_drop  (ccrx_frame_drop),
      .local_counter    (local_counter),
      .rx_data          (rx_data),
      .rx_protocol_ver  (rx_protocol_ver),
      .rx_gateware_type (rx_gateware_type),
      .rx_location      (rx_location),
      .rx_rev_id        (rx_rev_id),
      .rx_frame_counter (rx_frame_counter),
      .ccrx_fault_cnt   (ccrx_fault_cnt),
      .txrx_latency     (txrx_latency),
      .last_rx_counter  (last_rx_counter)
   );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the loopback testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module link_txrx_tb > sim.log 2>&1 \
   && ./obj_dir/Vlink_txrx_tb >> sim.log 2>&1 \
   || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
